// ==== all.f ====
+incdir+common
common/eth_frame_pkg.sv
hdl/payload_buffer.sv
hdl/crc32_engine.sv
frame_tx/frame_fields.sv
frame_tx/frame_sequencer.sv
hdl/eth_frame_gen.sv
dv/eth_frame_gen_tb.sv

// ==== common/eth_frame_macros.svh ====
`ifndef ETH_FRAME_MACROS_SVH
`define ETH_FRAME_MACROS_SVH

// preamble and start of frame delimiter
`define ETH_PREAMBLE_LEN   7
`define ETH_PREAMBLE_BYTE  8'h55
`define ETH_SFD_BYTE       8'hD5

// field sizes in bytes
`define ETH_HEADER_LEN     14     // dest + src + ethertype
`define ETH_MIN_PAYLOAD    46     // pad up to this
`define ETH_MAX_PAYLOAD    64     // payload buffer depth

// byte used for every payload and pad byte in fill mode
`define ETH_FILL_PATTERN   8'h55

// reflected ethernet crc-32
`define ETH_CRC_POLY_REFL  32'hEDB88320
`define ETH_CRC_INIT       32'hFFFF_FFFF

`endif

// ==== common/eth_frame_pkg.sv ====
package eth_frame_pkg;

    typedef logic [7:0]  byte_t;       // one frame byte
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] eth_type_t;
    typedef logic [31:0] crc_t;
    typedef logic [6:0]  pay_len_t;    // 0 .. 64
    typedef logic [5:0]  pay_addr_t;   // payload buffer address
    typedef logic [3:0]  hdr_idx_t;    // header byte 0 .. 13

    // code 3 is not listed, treated as normal
    typedef enum logic [1:0] {
        MODE_NORMAL = 2'd0,
        MODE_FILL   = 2'd1,   // payload and pad replaced by fill byte
        MODE_NO_PAD = 2'd2    // no padding to minimum size
    } frame_mode_e;

    // field currently sitting in the output register
    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_PREAMBLE = 3'd1,   // also carries the sfd
        ST_HEADER   = 3'd2,
        ST_PAYLOAD  = 3'd3,
        ST_PAD      = 3'd4,
        ST_FCS      = 3'd5
    } tx_state_e;

endpackage

// ==== dv/eth_frame_gen_tb.sv ====
`include "eth_frame_macros.svh"

module eth_frame_gen_tb
    import eth_frame_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // bytes of every frame sent below for the watchdog
    localparam int TOTAL_BYTES = 72 + 76 + 31 + 90 + 72 + 72;

    logic        clk;
    logic        i_rst_n;
    logic        i_pay_wr_en;
    pay_addr_t   i_pay_wr_addr;
    byte_t       i_pay_wr_data;
    logic        i_start;
    mac_addr_t   i_dest_addr;
    mac_addr_t   i_src_addr;
    eth_type_t   i_eth_type;
    pay_len_t    i_pay_len;
    frame_mode_e i_mode;
    logic        i_ready;
    logic        o_busy;
    logic        o_valid;
    logic        o_last;
    byte_t       o_data;

    integer      seed;
    int          err_data;                       // wrong byte or flag
    int          err_proto;                      // handshake and timing
    byte_t       pay_mem [0:`ETH_MAX_PAYLOAD-1]; // host copy of the buffer
    byte_t       exp_q [$];                      // bytes still to come
    logic        exp_avail;
    byte_t       exp_head;
    logic        exp_tail;                       // head is the final byte
    logic        rand_ready;
    logic [31:0] rdy_rnd;

    eth_frame_gen uut (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_pay_wr_en   (i_pay_wr_en),
        .i_pay_wr_addr (i_pay_wr_addr),
        .i_pay_wr_data (i_pay_wr_data),
        .i_start       (i_start),
        .i_dest_addr   (i_dest_addr),
        .i_src_addr    (i_src_addr),
        .i_eth_type    (i_eth_type),
        .i_pay_len     (i_pay_len),
        .i_mode        (i_mode),
        .i_ready       (i_ready),
        .o_busy        (o_busy),
        .o_valid       (o_valid),
        .o_last        (o_last),
        .o_data        (o_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // sink applies random back-pressure only when asked
    always @(posedge clk) begin
        #1;
        if (rand_ready) begin
            rdy_rnd = $random(seed);
            i_ready = rdy_rnd[0];
        end else begin
            i_ready = 1'b1;
        end
    end

    // head of queue refreshed mid-cycle so it is steady at the next edge
    always @(negedge clk) begin
        exp_avail <= (exp_q.size() != 0);
        exp_head  <= (exp_q.size() != 0) ? exp_q[0] : 8'h00;
        exp_tail  <= (exp_q.size() == 1);
    end

    // one expected byte consumed per transfer
    always @(posedge clk) begin
        if (i_rst_n && o_valid && i_ready && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
        end
    end

    a_rst_vals: assert property (@(posedge clk)
        $rose(i_rst_n) |-> !o_valid && !o_last && !o_busy && o_data == 8'h00)
        else begin
            err_proto++;
            $display("outputs not idle when reset was released at %0t", $time);
        end
    a_idle_quiet: assert property (@(posedge clk) disable iff (!i_rst_n)
        !o_busy |-> !o_valid && !o_last)
        else begin
            err_proto++;
            $display("valid or last high while not busy at %0t", $time);
        end
    a_start_first: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_start && !o_busy |=> o_busy && o_valid && !o_last && o_data == `ETH_PREAMBLE_BYTE)
        else begin
            err_proto++;
            $display("accepted start did not open a frame at %0t", $time);
        end
    a_busy_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_busy && !(o_valid && i_ready && o_last) |=> o_busy)
        else begin
            err_proto++;
            $display("busy dropped before the last transfer at %0t", $time);
        end
    a_end: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_valid && i_ready && o_last |=> !o_busy && !o_valid && !o_last)
        else begin
            err_proto++;
            $display("frame did not close after the last transfer at %0t", $time);
        end
    a_stall: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_valid && !i_ready |=> o_valid && $stable(o_data) && $stable(o_last))
        else begin
            err_proto++;
            $display("output moved during back-pressure at %0t", $time);
        end
    a_expected: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_valid |-> exp_avail)
        else begin
            err_proto++;
            $display("byte offered with no frame expected at %0t", $time);
        end
    a_data: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_valid && exp_avail |-> o_data == exp_head)
        else begin
            err_data++;
            $display("ERR %0t o_data expected %02h actual %02h",
                     $time, $sampled(exp_head), $sampled(o_data));
        end
    a_last: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_valid && exp_avail |-> o_last == exp_tail)
        else begin
            err_data++;
            $display("ERR %0t o_last expected %0b actual %0b",
                     $time, $sampled(exp_tail), $sampled(o_last));
        end

    // bit-serial lfsr form of the reflected crc-32
    task automatic crc_step(inout crc_t c, input byte_t d);
        int   b;
        logic fb;
        for (b = 0; b < 8; b++) begin
            fb = c[0] ^ d[b];          // data enters lsb first
            c  = c >> 1;
            if (fb) begin
                c = c ^ `ETH_CRC_POLY_REFL;
            end
        end
    endtask

    // standard check string 123456789 gives cbf43926
    task automatic check_crc_model();
        crc_t  c;
        string s;
        int    i;
        s = "123456789";
        c = `ETH_CRC_INIT;
        for (i = 0; i < s.len(); i++) begin
            crc_step(c, byte_t'(s[i]));
        end
        assert (~c == 32'hCBF4_3926) else begin
            err_data++;
            $display("ERR %0t crc_model expected cbf43926 actual %08h", $time, ~c);
        end
    endtask

    task automatic push_data(inout crc_t c, input byte_t d);
        exp_q.push_back(d);
        crc_step(c, d);
    endtask

    // expected frame bytes with the fcs last and low byte first
    task automatic build_frame(input mac_addr_t dest, input mac_addr_t src,
                               input eth_type_t et, input int len, input frame_mode_e mode);
        crc_t c;
        int   n;
        int   total;
        int   i;
        c     = `ETH_CRC_INIT;
        n     = (len > `ETH_MAX_PAYLOAD) ? `ETH_MAX_PAYLOAD : len;
        total = (mode == MODE_NO_PAD || n >= `ETH_MIN_PAYLOAD) ? n : `ETH_MIN_PAYLOAD;
        for (i = 0; i < `ETH_PREAMBLE_LEN; i++) begin
            exp_q.push_back(`ETH_PREAMBLE_BYTE);
        end
        exp_q.push_back(`ETH_SFD_BYTE);
        for (i = 0; i < 6; i++) begin
            push_data(c, dest[8*(5-i) +: 8]);   // msb first on the wire
        end
        for (i = 0; i < 6; i++) begin
            push_data(c, src[8*(5-i) +: 8]);
        end
        push_data(c, et[15:8]);
        push_data(c, et[7:0]);
        for (i = 0; i < total; i++) begin
            if (mode == MODE_FILL) begin
                push_data(c, `ETH_FILL_PATTERN);
            end else begin
                push_data(c, (i < n) ? pay_mem[i] : 8'h00);   // zero pad
            end
        end
        c = ~c;
        for (i = 0; i < 4; i++) begin
            exp_q.push_back(c[8*i +: 8]);
        end
    endtask

    // called and returns 1 ns after a rising edge
    task automatic load_payload(input int len);
        int i;
        for (i = 0; i < len; i++) begin
            pay_mem[i]    = byte_t'($random(seed));
            i_pay_wr_en   = 1'b1;
            i_pay_wr_addr = pay_addr_t'(i);
            i_pay_wr_data = pay_mem[i];
            @(posedge clk);
            #1;
        end
        i_pay_wr_en = 1'b0;
    endtask

    task automatic run_frame(input mac_addr_t dest, input mac_addr_t src, input eth_type_t et,
                             input int len, input frame_mode_e mode, input int exp_len,
                             input logic poke);
        int   cycles;
        logic done;
        build_frame(dest, src, et, len, mode);
        i_dest_addr = dest;
        i_src_addr  = src;
        i_eth_type  = et;
        i_pay_len   = pay_len_t'(len);
        i_mode      = mode;
        i_start     = 1'b1;
        @(posedge clk);
        #1;
        i_start = 1'b0;
        cycles  = 0;
        done    = 1'b0;
        while (!done) begin
            @(posedge clk);
            cycles++;
            done = o_valid && i_ready && o_last;
            #1;
            if (poke) begin
                // other config mid-frame and again alongside the final byte
                i_start     = (cycles == 20 || cycles == 21 || (o_last && !done));
                i_dest_addr = ~dest;
                i_pay_len   = 7'd3;
                i_mode      = MODE_NO_PAD;
            end
        end
        i_start = 1'b0;
        if (!rand_ready) begin
            assert (cycles == exp_len) else begin
                err_proto++;
                $display("ERR %0t frame_cycles expected %0d actual %0d", $time, exp_len, cycles);
            end
        end
        repeat (20) @(posedge clk);   // room for a stray second frame to show
        #1;
        assert (exp_q.size() == 0) else begin
            err_data++;
            $display("frame ended with %0d expected bytes never sent", exp_q.size());
            exp_q.delete();
        end
    endtask

    initial begin
        seed          = 32'h57e7_65b6;
        err_data      = 0;
        err_proto     = 0;
        rand_ready    = 1'b0;
        exp_avail     = 1'b0;
        exp_head      = 8'h00;
        exp_tail      = 1'b0;
        i_rst_n       = 1'b0;
        i_pay_wr_en   = 1'b0;
        i_pay_wr_addr = '0;
        i_pay_wr_data = '0;
        i_start       = 1'b0;
        i_dest_addr   = '0;
        i_src_addr    = '0;
        i_eth_type    = '0;
        i_pay_len     = '0;
        i_mode        = MODE_NORMAL;
        i_ready       = 1'b1;
        check_crc_model();
        repeat (3) @(posedge clk);
        #1;
        i_rst_n = 1'b1;
        @(posedge clk);
        #1;
        load_payload(10);    // padded to 46 with zeros
        run_frame(48'h0a1b_2c3d_4e5f, 48'h0200_0000_0001, 16'h0800, 10, MODE_NORMAL, 72, 1'b0);
        load_payload(50);    // fill pattern hides these
        run_frame(48'hffff_ffff_ffff, 48'h0200_0000_0002, 16'h88b5, 50, MODE_FILL, 76, 1'b0);
        load_payload(5);
        run_frame(48'h0180_c200_0001, 48'h0200_0000_0003, 16'h8808, 5, MODE_NO_PAD, 31, 1'b0);
        load_payload(64);    // length 70 clips to 64
        run_frame(48'h3333_0000_0001, 48'h0200_0000_0004, 16'h86dd, 70, MODE_NO_PAD, 90, 1'b0);
        load_payload(10);
        rand_ready = 1'b1;
        run_frame(48'h0a1b_2c3d_4e5f, 48'h0200_0000_0005, 16'h0800, 10, MODE_NORMAL, 72, 1'b0);
        rand_ready = 1'b0;
        @(posedge clk);      // sink back to always ready
        #1;
        load_payload(10);
        run_frame(48'h0a1b_2c3d_4e5f, 48'h0200_0000_0006, 16'h0806, 10, MODE_NORMAL, 72, 1'b1);
        $display("errors: data %0d, protocol %0d", err_data, err_proto);
        if (err_data + err_proto == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // twenty cycles per frame byte plus margin
    initial begin
        repeat (TOTAL_BYTES * 20 + 500) @(posedge clk);
        $display("timeout, run still going after %0d cycles", TOTAL_BYTES * 20 + 500);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== frame_tx/frame_fields.sv ====
`include "eth_frame_macros.svh"

module frame_fields
    import eth_frame_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_start,
    input  logic        i_busy,        // start ignored while high
    input  mac_addr_t   i_dest_addr,
    input  mac_addr_t   i_src_addr,
    input  eth_type_t   i_eth_type,
    input  pay_len_t    i_pay_len,
    input  frame_mode_e i_mode,
    input  hdr_idx_t    i_hdr_idx,     // header byte wanted by sequencer
    output pay_len_t    o_pay_len,     // clipped length
    output frame_mode_e o_mode,
    output byte_t       o_hdr_byte
);

    mac_addr_t dest_q;
    mac_addr_t src_q;
    eth_type_t type_q;
    logic      capture;

    assign capture = i_start && !i_busy;

    // length and mode steer the sequencer
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pay_len <= '0;
            o_mode    <= MODE_NORMAL;
        end else if (capture) begin
            if (i_pay_len > pay_len_t'(`ETH_MAX_PAYLOAD)) begin
                o_pay_len <= pay_len_t'(`ETH_MAX_PAYLOAD);   // clip to buffer depth
            end else begin
                o_pay_len <= i_pay_len;
            end
            o_mode <= i_mode;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            dest_q <= i_dest_addr;
            src_q  <= i_src_addr;
            type_q <= i_eth_type;
        end
    end

    // wire order, each field msb first
    always_comb begin
        if (i_hdr_idx < 4'd6) begin
            o_hdr_byte = dest_q[8*(5 - i_hdr_idx) +: 8];
        end else if (i_hdr_idx < 4'd12) begin
            o_hdr_byte = src_q[8*(11 - i_hdr_idx) +: 8];
        end else if (i_hdr_idx == 4'd12) begin
            o_hdr_byte = type_q[15:8];
        end else begin
            o_hdr_byte = type_q[7:0];    // idx 13, 14/15 never asked for
        end
    end

endmodule

// ==== frame_tx/frame_sequencer.sv ====
`include "eth_frame_macros.svh"

module frame_sequencer
    import eth_frame_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_start,
    input  logic        i_ready,        // sink accepts o_data
    input  pay_len_t    i_pay_len,      // captured, already clipped
    input  frame_mode_e i_mode,
    input  byte_t       i_hdr_byte,
    input  byte_t       i_pay_byte,
    input  crc_t        i_crc,
    output logic        o_busy,
    output logic        o_valid,
    output logic        o_last,
    output byte_t       o_data,
    output hdr_idx_t    o_hdr_idx,
    output pay_addr_t   o_pay_addr,
    output logic        o_crc_clear,
    output logic        o_crc_update,
    output byte_t       o_crc_data
);

    tx_state_e   state, nxt_state;     // field of the byte in o_data
    pay_len_t    cnt, nxt_cnt;         // index of that byte in its field
    pay_len_t    pad_len;
    crc_t        fcs_now;
    logic [23:0] fcs_hi;               // fcs bytes 1..3, byte 0 goes out directly
    byte_t       nxt_byte;
    byte_t       pay_byte;
    byte_t       pad_byte;
    logic        start_ok;
    logic        fire;
    logic        nxt_last;
    logic        load_fcs;

    assign start_ok = i_start && (state == ST_IDLE);
    assign fire     = o_valid && i_ready;
    assign o_busy   = (state != ST_IDLE);
    assign fcs_now  = ~i_crc;

    // zero pad up to the minimum unless no-pad mode
    always_comb begin
        if (i_mode == MODE_NO_PAD || i_pay_len >= pay_len_t'(`ETH_MIN_PAYLOAD)) begin
            pad_len = '0;
        end else begin
            pad_len = pay_len_t'(`ETH_MIN_PAYLOAD) - i_pay_len;
        end
    end

    assign pay_byte = (i_mode == MODE_FILL) ? `ETH_FILL_PATTERN : i_pay_byte;
    assign pad_byte = (i_mode == MODE_FILL) ? `ETH_FILL_PATTERN : 8'h00;

    // look one byte ahead of o_data
    assign o_hdr_idx  = (state == ST_HEADER) ? hdr_idx_t'(cnt + 7'd1) : '0;
    assign o_pay_addr = (state == ST_PAYLOAD) ? pay_addr_t'(cnt + 7'd1) : '0;

    always_comb begin
        nxt_state = state;
        nxt_cnt   = cnt + 7'd1;
        nxt_byte  = o_data;
        nxt_last  = 1'b0;
        load_fcs  = 1'b0;
        case (state)
            ST_PREAMBLE: begin
                if (cnt == pay_len_t'(`ETH_PREAMBLE_LEN)) begin   // sfd is out
                    nxt_state = ST_HEADER;
                    nxt_cnt   = '0;
                    nxt_byte  = i_hdr_byte;
                end else if (cnt == pay_len_t'(`ETH_PREAMBLE_LEN - 1)) begin
                    nxt_byte = `ETH_SFD_BYTE;
                end else begin
                    nxt_byte = `ETH_PREAMBLE_BYTE;
                end
            end
            ST_HEADER, ST_PAYLOAD, ST_PAD: begin
                if (state == ST_HEADER && cnt + 7'd1 < pay_len_t'(`ETH_HEADER_LEN)) begin
                    nxt_byte = i_hdr_byte;
                end else if (state == ST_PAYLOAD && cnt + 7'd1 < i_pay_len) begin
                    nxt_byte = pay_byte;
                end else if (state == ST_PAD && cnt + 7'd1 < pad_len) begin
                    nxt_byte = pad_byte;
                end else if (state == ST_HEADER && i_pay_len != '0) begin
                    nxt_state = ST_PAYLOAD;      // buffer addr 0 already selected
                    nxt_cnt   = '0;
                    nxt_byte  = pay_byte;
                end else if (state != ST_PAD && pad_len != '0) begin
                    nxt_state = ST_PAD;
                    nxt_cnt   = '0;
                    nxt_byte  = pad_byte;
                end else begin
                    // crc already holds the last data byte
                    nxt_state = ST_FCS;
                    nxt_cnt   = '0;
                    nxt_byte  = fcs_now[7:0];
                    load_fcs  = 1'b1;
                end
            end
            ST_FCS: begin
                case (cnt[1:0])
                    2'd0:    nxt_byte = fcs_hi[7:0];
                    2'd1:    nxt_byte = fcs_hi[15:8];
                    2'd2:    nxt_byte = fcs_hi[23:16];
                    default: nxt_byte = o_data;     // frame done, hold
                endcase
                nxt_last = (cnt == 7'd2);
                if (cnt == 7'd3) begin
                    nxt_state = ST_IDLE;
                    nxt_cnt   = '0;
                end
            end
            default: begin
                nxt_cnt = cnt;   // idle
            end
        endcase
    end

    // crc sees each data byte as it enters the output register
    assign o_crc_clear  = start_ok;
    assign o_crc_update = fire &&
                          (nxt_state == ST_HEADER || nxt_state == ST_PAYLOAD ||
                           nxt_state == ST_PAD);
    assign o_crc_data   = nxt_byte;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= ST_IDLE;
            cnt     <= '0;
            o_valid <= 1'b0;
            o_last  <= 1'b0;
            o_data  <= '0;
        end else if (start_ok) begin
            state   <= ST_PREAMBLE;
            cnt     <= '0;
            o_valid <= 1'b1;
            o_last  <= 1'b0;
            o_data  <= `ETH_PREAMBLE_BYTE;   // first preamble byte
        end else if (fire) begin
            state   <= nxt_state;
            cnt     <= nxt_cnt;
            o_valid <= (nxt_state != ST_IDLE);
            o_last  <= nxt_last;
            o_data  <= nxt_byte;
        end
    end

    // upper fcs bytes frozen once the last data byte leaves
    always_ff @(posedge clk) begin
        if (fire && load_fcs) begin
            fcs_hi <= fcs_now[31:8];
        end
    end

endmodule

// ==== hdl/crc32_engine.sv ====
`include "eth_frame_macros.svh"

module crc32_engine
    import eth_frame_pkg::*;
(
    input  logic  clk,
    input  logic  i_rst_n,
    input  logic  i_clear,     // load init value
    input  logic  i_update,    // fold in i_data
    input  byte_t i_data,
    output crc_t  o_crc        // running crc, not yet inverted
);

    crc_t crc_q;
    crc_t crc_next;

    // lsb first, one bit per step, eight steps per byte
    always_comb begin
        crc_next = crc_q ^ {24'h0, i_data};
        for (int b = 0; b < 8; b++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ `ETH_CRC_POLY_REFL;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            crc_q <= `ETH_CRC_INIT;
        end else if (i_clear) begin
            crc_q <= `ETH_CRC_INIT;     // new frame
        end else if (i_update) begin
            crc_q <= crc_next;
        end
    end

    assign o_crc = crc_q;

endmodule

// ==== hdl/eth_frame_gen.sv ====
module eth_frame_gen
    import eth_frame_pkg::*;
(
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_pay_wr_en,     // host payload write
    input  pay_addr_t   i_pay_wr_addr,
    input  byte_t       i_pay_wr_data,
    input  logic        i_start,         // taken only while not busy
    input  mac_addr_t   i_dest_addr,
    input  mac_addr_t   i_src_addr,
    input  eth_type_t   i_eth_type,
    input  pay_len_t    i_pay_len,
    input  frame_mode_e i_mode,
    input  logic        i_ready,         // sink side
    output logic        o_busy,
    output logic        o_valid,
    output logic        o_last,
    output byte_t       o_data
);

    pay_len_t    cfg_pay_len;
    frame_mode_e cfg_mode;
    hdr_idx_t    hdr_idx;
    byte_t       hdr_byte;
    pay_addr_t   pay_rd_addr;
    byte_t       pay_rd_data;
    logic        crc_clear;
    logic        crc_update;
    byte_t       crc_data;
    crc_t        crc;

    payload_buffer u_payload_buffer (
        .clk       (clk),
        .i_wr_en   (i_pay_wr_en),
        .i_wr_addr (i_pay_wr_addr),
        .i_wr_data (i_pay_wr_data),
        .i_rd_addr (pay_rd_addr),
        .o_rd_data (pay_rd_data)
    );

    crc32_engine u_crc32_engine (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_clear  (crc_clear),
        .i_update (crc_update),
        .i_data   (crc_data),
        .o_crc    (crc)
    );

    // config latched on the same edge the sequencer leaves idle
    frame_fields u_frame_fields (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_busy      (o_busy),
        .i_dest_addr (i_dest_addr),
        .i_src_addr  (i_src_addr),
        .i_eth_type  (i_eth_type),
        .i_pay_len   (i_pay_len),
        .i_mode      (i_mode),
        .i_hdr_idx   (hdr_idx),
        .o_pay_len   (cfg_pay_len),
        .o_mode      (cfg_mode),
        .o_hdr_byte  (hdr_byte)
    );

    frame_sequencer u_frame_sequencer (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_ready      (i_ready),
        .i_pay_len    (cfg_pay_len),
        .i_mode       (cfg_mode),
        .i_hdr_byte   (hdr_byte),
        .i_pay_byte   (pay_rd_data),
        .i_crc        (crc),
        .o_busy       (o_busy),
        .o_valid      (o_valid),
        .o_last       (o_last),
        .o_data       (o_data),
        .o_hdr_idx    (hdr_idx),
        .o_pay_addr   (pay_rd_addr),
        .o_crc_clear  (crc_clear),
        .o_crc_update (crc_update),
        .o_crc_data   (crc_data)
    );

endmodule

// ==== hdl/payload_buffer.sv ====
`include "eth_frame_macros.svh"

module payload_buffer
    import eth_frame_pkg::*;
(
    input  logic      clk,
    input  logic      i_wr_en,      // host write strobe
    input  pay_addr_t i_wr_addr,
    input  byte_t     i_wr_data,
    input  pay_addr_t i_rd_addr,    // from sequencer
    output byte_t     o_rd_data
);

    // host loads bytes before start, contents kept across frames
    byte_t mem [0:`ETH_MAX_PAYLOAD-1];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // async read so the sequencer gets the byte in the same cycle
    assign o_rd_data = mem[i_rd_addr];

endmodule
